// ==== logic/cpu_glue_pkg.sv ====
package cpu_glue_pkg;

    // Datapath widths
    typedef logic [31:0] addr_t;
    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_id_t;
    typedef logic [3:0]  wb_en_t;

    // Size code on the uncached data bus
    typedef logic [2:0]  xfer_size_t;

    // Memory operation of the instruction in execute
    typedef enum logic [2:0] {
        LS_NONE   = 3'd0,
        LS_BYTE   = 3'd1,
        LS_HALF   = 3'd2,
        LS_WORD   = 3'd3,
        LS_LINKED = 3'd4
    } ls_kind_t;

    localparam xfer_size_t SIZE_BYTE = 3'b000;
    localparam xfer_size_t SIZE_HALF = 3'b001;
    localparam xfer_size_t SIZE_WORD = 3'b010;

    // Core reset outlasts the external one by this many cycles
    localparam int RESET_HOLD_CYCLES = 128;
    localparam int RESET_CNT_W       = $clog2(RESET_HOLD_CYCLES);

    // Fetches to complete before the instruction cache is trusted
    localparam int WARMUP_FETCHES = 3;
    localparam int WARMUP_CNT_W   = $clog2(WARMUP_FETCHES + 1);

    typedef logic [WARMUP_CNT_W-1:0] warmup_cnt_t;

    localparam wb_en_t WB_EN_ALL = 4'b1111;

endpackage

// ==== logic/reset_stretcher.sv ====
`timescale 1ns/10ps

module reset_stretcher (
    input  logic Clk,
    input  logic Myreset,
    output logic o_core_reset
);

    logic                                core_hold;
    logic [cpu_glue_pkg::RESET_CNT_W-1:0] hold_cnt;

    // Count from the first edge with the external reset released
    always_ff @(posedge Clk) begin
        if (Myreset) begin
            core_hold <= 1'b1;
            hold_cnt  <= '0;
        end else if (core_hold) begin
            hold_cnt <= hold_cnt + 1'b1;
            // Last count, release on this edge
            if (&hold_cnt) begin
                core_hold <= 1'b0;
            end
        end
    end

    assign o_core_reset = Myreset | core_hold;

endmodule

// ==== logic/icache_warmup.sv ====
`timescale 1ns/10ps

module icache_warmup (
    input  logic Clk,
    input  logic i_core_reset,
    input  logic i_inst_data_ok,
    input  logic i_dcache_close,
    output logic o_cache_bypass
);

    logic                      icache_close;
    cpu_glue_pkg::warmup_cnt_t fetch_cnt;

    always_ff @(posedge Clk) begin
        if (i_core_reset) begin
            icache_close <= 1'b1;
            fetch_cnt    <= cpu_glue_pkg::warmup_cnt_t'(cpu_glue_pkg::WARMUP_FETCHES);
        end else begin
            if (i_inst_data_ok && fetch_cnt != '0) begin
                fetch_cnt <= fetch_cnt - 1'b1;
            end
            // Opens one edge after the count is spent
            if (fetch_cnt == '0) begin
                icache_close <= 1'b0;
            end
        end
    end

    // Data-cache close from CP0 also forces bypass
    assign o_cache_bypass = icache_close | i_dcache_close;

endmodule

// ==== logic/data_req_router.sv ====
`timescale 1ns/10ps

module data_req_router (
    input  cpu_glue_pkg::ls_kind_t   i_ls_kind,
    input  logic                     i_ls_store,
    input  logic                     i_uncached,
    input  logic                     i_exception,
    output logic                     o_dcache_read,
    output logic                     o_dcache_write,
    output logic                     o_dsram_read,
    output logic                     o_dsram_write,
    output cpu_glue_pkg::xfer_size_t o_dsram_size
);

    logic is_mem;
    logic req_read;
    logic req_write;

    assign is_mem = (i_ls_kind != cpu_glue_pkg::LS_NONE);

    // Pending exception kills the request before it reaches memory
    assign req_read  = is_mem & ~i_ls_store & ~i_exception;
    assign req_write = is_mem & i_ls_store & ~i_exception;

    assign o_dcache_read  = req_read & ~i_uncached;
    assign o_dcache_write = req_write & ~i_uncached;
    assign o_dsram_read   = req_read & i_uncached;
    assign o_dsram_write  = req_write & i_uncached;

    always_comb begin
        case (i_ls_kind)
            cpu_glue_pkg::LS_WORD,
            cpu_glue_pkg::LS_LINKED: o_dsram_size = cpu_glue_pkg::SIZE_WORD;
            cpu_glue_pkg::LS_HALF:   o_dsram_size = cpu_glue_pkg::SIZE_HALF;
            default:                 o_dsram_size = cpu_glue_pkg::SIZE_BYTE;
        endcase
    end

endmodule

// ==== logic/writeback_stage.sv ====
`timescale 1ns/10ps

module writeback_stage (
    input  logic                  Clk,
    input  logic                  i_core_reset,
    input  logic                  i_mem_stall,
    input  logic                  i_flush,
    input  logic                  i_exception,
    input  cpu_glue_pkg::addr_t   i_wb_pc,
    input  cpu_glue_pkg::word_t   i_wb_data,
    input  cpu_glue_pkg::reg_id_t i_wb_reg,
    input  logic                  i_wb_wen,
    output cpu_glue_pkg::addr_t   o_debug_pc,
    output cpu_glue_pkg::word_t   o_debug_wdata,
    output cpu_glue_pkg::reg_id_t o_debug_wnum,
    output cpu_glue_pkg::wb_en_t  o_debug_wen
);

    cpu_glue_pkg::addr_t   wb_pc_q;
    cpu_glue_pkg::word_t   wb_data_q;
    cpu_glue_pkg::reg_id_t wb_reg_q;
    logic                  wb_wen_q;
    logic                  retire;

    // Retiring instruction, frozen while memory stalls
    always_ff @(posedge Clk) begin
        if (i_core_reset) begin
            wb_pc_q   <= '0;
            wb_data_q <= '0;
            wb_reg_q  <= '0;
            wb_wen_q  <= 1'b0;
        end else if (!i_mem_stall) begin
            wb_pc_q   <= i_wb_pc;
            wb_data_q <= i_wb_data;
            wb_reg_q  <= i_wb_reg;
            wb_wen_q  <= i_wb_wen;
        end
    end

    // A stalled write only counts when an exception retires it
    assign retire = wb_wen_q & (~i_mem_stall | i_exception) & ~i_flush;

    // Flush hides the held entry without losing it
    assign o_debug_pc    = i_flush ? '0 : wb_pc_q;
    assign o_debug_wdata = i_flush ? '0 : wb_data_q;
    assign o_debug_wnum  = i_flush ? '0 : wb_reg_q;
    assign o_debug_wen   = retire ? cpu_glue_pkg::WB_EN_ALL : '0;

endmodule

// ==== logic/cpu_glue_top.sv ====
`timescale 1ns/10ps

module cpu_glue_top (
    input  logic                     Clk,
    input  logic                     Myreset,
    input  logic                     i_inst_data_ok,
    input  logic                     i_dcache_close,
    input  cpu_glue_pkg::ls_kind_t   i_ls_kind,
    input  logic                     i_ls_store,
    input  logic                     i_uncached,
    input  logic                     i_exception,
    input  logic                     i_mem_stall,
    input  logic                     i_flush,
    input  cpu_glue_pkg::addr_t      i_wb_pc,
    input  cpu_glue_pkg::word_t      i_wb_data,
    input  cpu_glue_pkg::reg_id_t    i_wb_reg,
    input  logic                     i_wb_wen,
    output logic                     o_core_reset,
    output logic                     o_cache_bypass,
    output logic                     o_dcache_read,
    output logic                     o_dcache_write,
    output logic                     o_dsram_read,
    output logic                     o_dsram_write,
    output cpu_glue_pkg::xfer_size_t o_dsram_size,
    output cpu_glue_pkg::addr_t      o_debug_pc,
    output cpu_glue_pkg::word_t      o_debug_wdata,
    output cpu_glue_pkg::reg_id_t    o_debug_wnum,
    output cpu_glue_pkg::wb_en_t     o_debug_wen
);

    logic core_reset;

    assign o_core_reset = core_reset;

    reset_stretcher u_reset_stretcher (
        .Clk          (Clk),
        .Myreset      (Myreset),
        .o_core_reset (core_reset)
    );

    icache_warmup u_icache_warmup (
        .Clk            (Clk),
        .i_core_reset   (core_reset),
        .i_inst_data_ok (i_inst_data_ok),
        .i_dcache_close (i_dcache_close),
        .o_cache_bypass (o_cache_bypass)
    );

    // Request side, straight from execute
    data_req_router u_data_req_router (
        .i_ls_kind      (i_ls_kind),
        .i_ls_store     (i_ls_store),
        .i_uncached     (i_uncached),
        .i_exception    (i_exception),
        .o_dcache_read  (o_dcache_read),
        .o_dcache_write (o_dcache_write),
        .o_dsram_read   (o_dsram_read),
        .o_dsram_write  (o_dsram_write),
        .o_dsram_size   (o_dsram_size)
    );

    writeback_stage u_writeback_stage (
        .Clk           (Clk),
        .i_core_reset  (core_reset),
        .i_mem_stall   (i_mem_stall),
        .i_flush       (i_flush),
        .i_exception   (i_exception),
        .i_wb_pc       (i_wb_pc),
        .i_wb_data     (i_wb_data),
        .i_wb_reg      (i_wb_reg),
        .i_wb_wen      (i_wb_wen),
        .o_debug_pc    (o_debug_pc),
        .o_debug_wdata (o_debug_wdata),
        .o_debug_wnum  (o_debug_wnum),
        .o_debug_wen   (o_debug_wen)
    );

endmodule

// ==== tests/cpu_glue_chk.sv ====
`timescale 1ns/10ps

module cpu_glue_chk (
    input  logic                 Clk,
    input  logic                 Myreset,
    input  logic                 i_dcache_read,
    input  logic                 i_dcache_write,
    input  logic                 i_dsram_read,
    input  logic                 i_dsram_write,
    input  cpu_glue_pkg::wb_en_t i_debug_wen
);

    // One read path at a time
    read_path_unique: assert property (@(posedge Clk) disable iff (Myreset)
        !(i_dcache_read && i_dsram_read))
        else $error("cached and uncached reads both active");

    read_write_exclusive: assert property (@(posedge Clk) disable iff (Myreset)
        !((i_dcache_read || i_dsram_read) && (i_dcache_write || i_dsram_write)))
        else $error("read and write strobes active together");

    // Byte enables move as one
    debug_wen_whole: assert property (@(posedge Clk) disable iff (Myreset)
        (i_debug_wen == 4'h0) || (i_debug_wen == cpu_glue_pkg::WB_EN_ALL))
        else $error("partial debug write enable");

endmodule

bind cpu_glue_top cpu_glue_chk i_cpu_glue_chk (
    .Clk            (Clk),
    .Myreset        (Myreset),
    .i_dcache_read  (o_dcache_read),
    .i_dcache_write (o_dcache_write),
    .i_dsram_read   (o_dsram_read),
    .i_dsram_write  (o_dsram_write),
    .i_debug_wen    (o_debug_wen)
);

// ==== tests/cpu_glue_tb.sv ====
`timescale 1ns/10ps

module cpu_glue_tb;

    localparam int N_ENTRIES    = 40;
    localparam int RESET_CYCLES = 5;
    localparam int WARMUP_STEPS = 2 * cpu_glue_pkg::WARMUP_FETCHES + 3;
    localparam int WATCHDOG_CYCLES =
        2 * (RESET_CYCLES + cpu_glue_pkg::RESET_HOLD_CYCLES + 3 + WARMUP_STEPS + N_ENTRIES);

    typedef struct packed {
        cpu_glue_pkg::ls_kind_t   kind;
        logic                     store;
        logic                     uncached;
        logic                     exception;
        logic                     stall;
        logic                     flush;
        cpu_glue_pkg::addr_t      pc;
        cpu_glue_pkg::word_t      data;
        cpu_glue_pkg::reg_id_t    rnum;
        logic                     wen;
        logic                     exp_dc_rd;
        logic                     exp_dc_wr;
        logic                     exp_sr_rd;
        logic                     exp_sr_wr;
        cpu_glue_pkg::xfer_size_t exp_size;
        cpu_glue_pkg::addr_t      exp_pc;
        cpu_glue_pkg::word_t      exp_data;
        cpu_glue_pkg::reg_id_t    exp_wnum;
        cpu_glue_pkg::wb_en_t     exp_wen;
    } entry_t;

    logic                     Clk;
    logic                     Myreset;
    logic                     i_inst_data_ok;
    logic                     i_dcache_close;
    cpu_glue_pkg::ls_kind_t   i_ls_kind;
    logic                     i_ls_store;
    logic                     i_uncached;
    logic                     i_exception;
    logic                     i_mem_stall;
    logic                     i_flush;
    cpu_glue_pkg::addr_t      i_wb_pc;
    cpu_glue_pkg::word_t      i_wb_data;
    cpu_glue_pkg::reg_id_t    i_wb_reg;
    logic                     i_wb_wen;
    logic                     o_core_reset;
    logic                     o_cache_bypass;
    logic                     o_dcache_read;
    logic                     o_dcache_write;
    logic                     o_dsram_read;
    logic                     o_dsram_write;
    cpu_glue_pkg::xfer_size_t o_dsram_size;
    cpu_glue_pkg::addr_t      o_debug_pc;
    cpu_glue_pkg::word_t      o_debug_wdata;
    cpu_glue_pkg::reg_id_t    o_debug_wnum;
    cpu_glue_pkg::wb_en_t     o_debug_wen;

    entry_t entries [N_ENTRIES];
    integer seed;

    cpu_glue_top i_cpu_glue_top (.*);

    always #2 Clk = ~Clk;

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("Error: %s got 0x%h expected 0x%h", name, actual, expected);
            $display("TEST RESULT: FAIL");
            $fatal(1, "Stopping at first mismatch");
        end
    endtask

    task automatic check_reset_state();
        check_value("o_core_reset", 32'(o_core_reset), 32'h1);
        check_value("o_cache_bypass", 32'(o_cache_bypass), 32'h1);
        check_value("o_debug_wen", 32'(o_debug_wen), 32'h0);
        check_value("o_dcache_read", 32'(o_dcache_read), 32'h0);
        check_value("o_dcache_write", 32'(o_dcache_write), 32'h0);
        check_value("o_dsram_read", 32'(o_dsram_read), 32'h0);
        check_value("o_dsram_write", 32'(o_dsram_write), 32'h0);
    endtask

    // Stimulus first, then expected values from a model of the retire register
    task automatic build_table();
        cpu_glue_pkg::addr_t   hold_pc;
        cpu_glue_pkg::word_t   hold_data;
        cpu_glue_pkg::reg_id_t hold_reg;
        logic                  hold_wen;
        logic                  rd;
        logic                  wr;
        hold_pc   = '0;
        hold_data = '0;
        hold_reg  = '0;
        hold_wen  = 1'b0;
        for (int i = 0; i < N_ENTRIES; i++) begin
            // First 20 entries sweep every kind, direction and path
            entries[i].kind      = cpu_glue_pkg::ls_kind_t'(3'(i % 5));
            entries[i].store     = ((i / 5) % 2) == 1;
            entries[i].uncached  = ((i / 10) % 2) == 1;
            entries[i].exception = (i >= 20) && (i % 3 == 0);
            entries[i].stall     = (i >= 6 && i <= 8) || (i >= 25 && i <= 28);
            entries[i].flush     = (i == 12) || (i == 13) || (i == 25) || (i == 33);
            entries[i].pc        = $random(seed);
            entries[i].data      = $random(seed);
            entries[i].rnum      = 5'($random(seed));
            entries[i].wen       = (i % 4) != 3;

            rd = (entries[i].kind != cpu_glue_pkg::LS_NONE) && !entries[i].store
                 && !entries[i].exception;
            wr = (entries[i].kind != cpu_glue_pkg::LS_NONE) && entries[i].store
                 && !entries[i].exception;
            entries[i].exp_dc_rd = rd && !entries[i].uncached;
            entries[i].exp_dc_wr = wr && !entries[i].uncached;
            entries[i].exp_sr_rd = rd && entries[i].uncached;
            entries[i].exp_sr_wr = wr && entries[i].uncached;
            if (entries[i].kind == cpu_glue_pkg::LS_WORD ||
                entries[i].kind == cpu_glue_pkg::LS_LINKED) begin
                entries[i].exp_size = cpu_glue_pkg::SIZE_WORD;
            end else if (entries[i].kind == cpu_glue_pkg::LS_HALF) begin
                entries[i].exp_size = cpu_glue_pkg::SIZE_HALF;
            end else begin
                entries[i].exp_size = cpu_glue_pkg::SIZE_BYTE;
            end

            entries[i].exp_pc   = entries[i].flush ? '0 : hold_pc;
            entries[i].exp_data = entries[i].flush ? '0 : hold_data;
            entries[i].exp_wnum = entries[i].flush ? '0 : hold_reg;
            entries[i].exp_wen  = (hold_wen && !entries[i].flush &&
                                   (!entries[i].stall || entries[i].exception)) ? 4'hf : 4'h0;
            // Captured on the next edge unless stalled
            if (!entries[i].stall) begin
                hold_pc   = entries[i].pc;
                hold_data = entries[i].data;
                hold_reg  = entries[i].rnum;
                hold_wen  = entries[i].wen;
            end
        end
    endtask

    task automatic drive_entry(input entry_t e);
        i_ls_kind   = e.kind;
        i_ls_store  = e.store;
        i_uncached  = e.uncached;
        i_exception = e.exception;
        i_mem_stall = e.stall;
        i_flush     = e.flush;
        i_wb_pc     = e.pc;
        i_wb_data   = e.data;
        i_wb_reg    = e.rnum;
        i_wb_wen    = e.wen;
    endtask

    task automatic check_entry(input entry_t e);
        check_value("o_dcache_read", 32'(o_dcache_read), 32'(e.exp_dc_rd));
        check_value("o_dcache_write", 32'(o_dcache_write), 32'(e.exp_dc_wr));
        check_value("o_dsram_read", 32'(o_dsram_read), 32'(e.exp_sr_rd));
        check_value("o_dsram_write", 32'(o_dsram_write), 32'(e.exp_sr_wr));
        check_value("o_dsram_size", 32'(o_dsram_size), 32'(e.exp_size));
        check_value("o_debug_pc", o_debug_pc, e.exp_pc);
        check_value("o_debug_wdata", o_debug_wdata, e.exp_data);
        check_value("o_debug_wnum", 32'(o_debug_wnum), 32'(e.exp_wnum));
        check_value("o_debug_wen", 32'(o_debug_wen), 32'(e.exp_wen));
    endtask

    // One-cycle fetch completion with bypass still high after it
    task automatic fetch_pulse();
        @(posedge Clk);
        #0.5;
        i_inst_data_ok = 1'b1;
        @(negedge Clk);
        check_value("o_cache_bypass", 32'(o_cache_bypass), 32'h1);
        @(posedge Clk);
        #0.5;
        i_inst_data_ok = 1'b0;
        @(negedge Clk);
        check_value("o_cache_bypass", 32'(o_cache_bypass), 32'h1);
    endtask

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge Clk);
        $display("Timeout: the run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("TEST RESULT: FAIL");
        $fatal(1, "Watchdog expired");
    end

    initial begin
        seed           = 32'h72fe19de;
        Clk            = 1'b0;
        Myreset        = 1'b1;
        i_inst_data_ok = 1'b0;
        i_dcache_close = 1'b0;
        i_ls_kind      = cpu_glue_pkg::LS_NONE;
        i_ls_store     = 1'b0;
        i_uncached     = 1'b0;
        i_exception    = 1'b0;
        i_mem_stall    = 1'b0;
        i_flush        = 1'b0;
        i_wb_pc        = '0;
        i_wb_data      = '0;
        i_wb_reg       = '0;
        // Write pending during reset so the register clear is visible
        i_wb_wen       = 1'b1;
        build_table();

        @(posedge Clk);
        repeat (RESET_CYCLES - 1) begin
            @(negedge Clk);
            check_reset_state();
            @(posedge Clk);
        end
        #0.5;
        Myreset  = 1'b0;
        i_wb_wen = 1'b0;

        // Core reset outlasts Myreset by exactly RESET_HOLD_CYCLES edges
        for (int n = 1; n <= cpu_glue_pkg::RESET_HOLD_CYCLES + 3; n++) begin
            @(posedge Clk);
            @(negedge Clk);
            check_value("o_core_reset", 32'(o_core_reset),
                        32'(n < cpu_glue_pkg::RESET_HOLD_CYCLES));
            check_value("o_cache_bypass", 32'(o_cache_bypass), 32'h1);
        end

        repeat (cpu_glue_pkg::WARMUP_FETCHES) fetch_pulse();
        @(posedge Clk);
        @(negedge Clk);
        check_value("o_cache_bypass", 32'(o_cache_bypass), 32'h0);
        @(posedge Clk);
        #0.5;
        i_dcache_close = 1'b1;
        @(negedge Clk);
        check_value("o_cache_bypass", 32'(o_cache_bypass), 32'h1);
        @(posedge Clk);
        #0.5;
        i_dcache_close = 1'b0;
        @(negedge Clk);
        check_value("o_cache_bypass", 32'(o_cache_bypass), 32'h0);

        for (int i = 0; i < N_ENTRIES; i++) begin
            @(posedge Clk);
            #0.5;
            drive_entry(entries[i]);
            @(negedge Clk);
            check_entry(entries[i]);
        end

        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

// ==== flist.f ====
logic/cpu_glue_pkg.sv
logic/reset_stretcher.sv
logic/icache_warmup.sv
logic/data_req_router.sv
logic/writeback_stage.sv
logic/cpu_glue_top.sv
tests/cpu_glue_chk.sv
tests/cpu_glue_tb.sv

// ==== Makefile ====
TOOL       = verilator
FLAGS      = --binary --timing --assert -j 0
LINT_FLAGS = --lint-only --timing -Wall
TOP        = cpu_glue_tb
FLIST      = flist.f
BUILD_DIR  = obj_dir
LOG        = sim.log
PASS_TEXT  = TEST RESULT: PASS

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FLIST) -Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q "$(PASS_TEXT)" $(LOG)

lint:
	$(TOOL) $(LINT_FLAGS) --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
